/* gcode_line_parser.f */
gcode_pkg.sv
char_classifier.sv
line_tokenizer.sv
cmd_word_parser.sv
axis_word_parser.sv
op_assembler.sv
gcode_line_parser.sv
tb_gcode_line_parser.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = tb_gcode_line_parser
FILELIST = gcode_line_parser.f
BUILD = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf $(BUILD)

/* tb_gcode_line_parser.sv */
`timescale 1ns/10ps

module tb_gcode_line_parser;

	localparam int NUM_AXES = 3;
	localparam int COORD_BITS = gcode_pkg::COORD_BITS;
	localparam int MAX_OPS = 128;

	typedef logic [NUM_AXES-1:0][COORD_BITS-1:0] values_t;

	logic clk;
	logic reset;
	logic char_valid;
	gcode_pkg::byte_t char_in;
	logic op_valid;
	gcode_pkg::cmd_t op_cmd;
	logic [NUM_AXES-1:0] op_axis_present;
	values_t op_axis_value;
	logic op_error;

	// expected operations in order, filled before each line goes out
	gcode_pkg::cmd_t exp_cmd [MAX_OPS];
	logic [NUM_AXES-1:0] exp_present [MAX_OPS];
	values_t exp_value [MAX_OPS];
	logic exp_error [MAX_OPS];
	int wr_cnt = 0;
	int rd_cnt = 0;

	logic line_emits = 1'b0;  // line on the wire gives an operation
	logic [1:0] nl_pipe;  // newline two edges back
	logic [31:0] rng;
	int errors = 0;
	int cycles = 0;
	int cycle_limit = 0;
	string lines[$];
	int line_test[$];
	string test_name[5];

	gcode_line_parser #(
		.NUM_AXES(NUM_AXES),
		.COORD_BITS(COORD_BITS)
	) i_gcode_line_parser (
		.clk(clk),
		.reset(reset),
		.char_valid(char_valid),
		.char_in(char_in),
		.op_valid(op_valid),
		.op_cmd(op_cmd),
		.op_axis_present(op_axis_present),
		.op_axis_value(op_axis_value),
		.op_error(op_error)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		if (reset) begin
			rd_cnt <= 0;
			nl_pipe <= '0;
		end else begin
			if (op_valid) rd_cnt <= rd_cnt + 1;  // pop the checked entry
			nl_pipe <= {nl_pipe[0], char_valid && char_in == "\n" && line_emits};
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic int rand_below(input int n);
		rng = rng * 32'd1664525 + 32'd1013904223;
		return int'(rng[30:8]) % n;
	endfunction

	function automatic gcode_pkg::cmd_t cmd_of(input int g);
		case (g)
			0: return gcode_pkg::CMD_RAPID;
			1: return gcode_pkg::CMD_LINEAR;
			28: return gcode_pkg::CMD_HOME;
			90: return gcode_pkg::CMD_ABSOLUTE;
			91: return gcode_pkg::CMD_RELATIVE;
			default: return gcode_pkg::CMD_NONE;
		endcase
	endfunction

	// absent axes read as zero
	function automatic values_t keep_present(input values_t v, input logic [NUM_AXES-1:0] p);
		values_t r;
		r = '0;
		for (int i = 0; i < NUM_AXES; i++) begin
			if (p[i]) r[i] = v[i];
		end
		return r;
	endfunction

	task automatic model_line(input string s, output gcode_pkg::cmd_t cmd,
			output logic [NUM_AXES-1:0] present, output values_t value,
			output logic error, output logic nonempty);
		int owner;  // -1 no field, 0 command, lane + 1 for an axis
		int gnum;
		int lane;
		int v;
		int mag [NUM_AXES];
		int frac [NUM_AXES];
		bit neg [NUM_AXES];
		bit point [NUM_AXES];
		bit started [NUM_AXES];
		bit has_digit [NUM_AXES];
		bit lane_err [NUM_AXES];
		bit in_comment;
		bit bad;
		bit cmd_seen;
		bit cmd_digit;
		bit cmd_err;
		gcode_pkg::byte_t c;
		owner = -1;
		gnum = 0;
		in_comment = 0;
		bad = 0;
		cmd_seen = 0;
		cmd_digit = 0;
		cmd_err = 0;
		present = '0;
		nonempty = 1'b0;
		for (int i = 0; i < NUM_AXES; i++) begin
			mag[i] = 0;
			frac[i] = 0;
			neg[i] = 0;
			point[i] = 0;
			started[i] = 0;
			has_digit[i] = 0;
			lane_err[i] = 0;
		end
		for (int k = 0; k < s.len(); k++) begin
			c = s[k];
			if (c >= "a" && c <= "z") c = c - 8'd32;
			lane = -1;
			for (int i = 0; i < NUM_AXES; i++) begin
				if (c == gcode_pkg::AXIS_LETTERS[i]) lane = i;
			end
			if (in_comment) begin
				// dropped up to the newline
			end else if (c == "G") begin
				nonempty = 1'b1;
				cmd_err |= cmd_seen;
				cmd_seen = 1;
				cmd_digit = 0;
				gnum = 0;
				owner = 0;
			end else if (lane >= 0) begin
				nonempty = 1'b1;
				lane_err[lane] |= present[lane];  // axis given twice
				present[lane] = 1'b1;
				mag[lane] = 0;
				frac[lane] = 0;
				neg[lane] = 0;
				point[lane] = 0;
				started[lane] = 0;
				has_digit[lane] = 0;
				owner = lane + 1;
			end else if ((c >= "0" && c <= "9") || c == "-" || c == ".") begin
				if (owner < 0) begin
					bad = 1;
				end else if (owner == 0) begin
					if (c >= "0" && c <= "9") begin
						cmd_digit = 1;
						gnum = gnum * 10 + int'(c - "0");
						if (gnum > 127) gnum = 127;
					end else begin
						cmd_err = 1;
					end
				end else begin
					lane = owner - 1;
					if (c == "-") begin
						lane_err[lane] |= started[lane];
						neg[lane] = 1;
					end else if (c == ".") begin
						lane_err[lane] |= point[lane];
						point[lane] = 1;
					end else if (point[lane] && frac[lane] == gcode_pkg::FRAC_DIGITS) begin
						lane_err[lane] = 1;
					end else begin
						mag[lane] = mag[lane] * 10 + int'(c - "0");
						has_digit[lane] = 1;
						if (point[lane]) frac[lane]++;
					end
					started[lane] = 1;
				end
			end else if (c == " " || c == "\t" || c == "\r") begin
				owner = -1;
			end else if (c == ";") begin
				owner = -1;
				in_comment = 1;
			end else begin
				bad = 1;
			end
		end
		cmd = cmd_digit ? cmd_of(gnum) : gcode_pkg::CMD_NONE;
		error = bad || cmd_err || !cmd_digit || cmd_of(gnum) == gcode_pkg::CMD_NONE;
		value = '0;
		for (int i = 0; i < NUM_AXES; i++) begin
			v = mag[i];
			for (int k = frac[i]; k < gcode_pkg::FRAC_DIGITS; k++) v = v * 10;
			value[i] = COORD_BITS'(neg[i] ? -v : v);
			if (lane_err[i] || (present[i] && !has_digit[i])) error = 1'b1;
		end
	endtask

	task automatic send_line(input string s, input bit gaps);
		gcode_pkg::cmd_t cmd;
		logic [NUM_AXES-1:0] present;
		values_t value;
		logic error;
		logic nonempty;
		model_line(s, cmd, present, value, error, nonempty);
		if (nonempty) begin
			exp_cmd[wr_cnt] = cmd;
			exp_present[wr_cnt] = present;
			exp_value[wr_cnt] = value;
			exp_error[wr_cnt] = error;
			wr_cnt++;
		end
		line_emits = nonempty;
		for (int k = 0; k <= s.len(); k++) begin
			if (gaps && rand_below(8) == 0) begin
				char_valid = 1'b0;
				@(negedge clk);
			end
			char_valid = 1'b1;
			char_in = (k == s.len()) ? "\n" : s[k];
			@(negedge clk);
		end
		char_valid = 1'b0;
	endtask

	function automatic string random_line();
		string s;
		int order [NUM_AXES];
		int j;
		int t;
		int nfrac;
		s = "G1";
		for (int i = 0; i < NUM_AXES; i++) order[i] = i;
		for (int i = NUM_AXES - 1; i > 0; i--) begin
			j = rand_below(i + 1);
			t = order[i];
			order[i] = order[j];
			order[j] = t;
		end
		for (int i = 0; i < NUM_AXES; i++) begin
			if (i == 0 || rand_below(4) != 0) begin
				s = $sformatf("%s %c", s, gcode_pkg::AXIS_LETTERS[order[i]]);
				if (rand_below(2) == 1) s = $sformatf("%s-", s);
				s = $sformatf("%s%0d", s, rand_below(5000));  // stays inside 24 bits
				nfrac = rand_below(4);
				if (nfrac > 0) s = $sformatf("%s.", s);
				for (int k = 0; k < nfrac; k++) s = $sformatf("%s%0d", s, rand_below(10));
			end
		end
		return s;
	endfunction

	task automatic add_line(input int t, input string s);
		lines.push_back(s);
		line_test.push_back(t);
	endtask

	task automatic finish_test(input int t, input int n_lines, inout int errors_before);
		while (rd_cnt < wr_cnt || nl_pipe != 0) @(negedge clk);
		repeat (2) @(negedge clk);
		$display("test %0d %s: %0d lines, %0d errors", t, test_name[t], n_lines,
			errors - errors_before);
		errors_before = errors;
	endtask

	a_op_expected: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> rd_cnt < wr_cnt)
		else begin
			$display("op_valid came while no operation was expected");
			errors = errors + 1;
		end

	a_latency: assert property (@(posedge clk) disable iff (reset)
		op_valid == nl_pipe[1])
		else begin
			$display("[ERROR] op_valid got %h expected %h", $sampled(op_valid),
				$sampled(nl_pipe[1]));
			errors = errors + 1;
		end

	a_cmd: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> op_cmd == exp_cmd[rd_cnt])
		else begin
			$display("[ERROR] op_cmd got %h expected %h", $sampled(op_cmd),
				exp_cmd[$sampled(rd_cnt)]);
			errors = errors + 1;
		end

	a_present: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> op_axis_present == exp_present[rd_cnt])
		else begin
			$display("[ERROR] op_axis_present got %h expected %h", $sampled(op_axis_present),
				exp_present[$sampled(rd_cnt)]);
			errors = errors + 1;
		end

	a_error: assert property (@(posedge clk) disable iff (reset)
		op_valid |-> op_error == exp_error[rd_cnt])
		else begin
			$display("[ERROR] op_error got %h expected %h", $sampled(op_error),
				exp_error[$sampled(rd_cnt)]);
			errors = errors + 1;
		end

	// values are only defined for clean lines
	a_values: assert property (@(posedge clk) disable iff (reset)
		op_valid && !exp_error[rd_cnt] |->
			keep_present(op_axis_value, exp_present[rd_cnt]) == exp_value[rd_cnt])
		else begin
			$display("[ERROR] op_axis_value got %h expected %h", $sampled(op_axis_value),
				exp_value[$sampled(rd_cnt)]);
			errors = errors + 1;
		end

	initial begin
		int last_test;
		int n_lines;
		int errors_before;
		int total;
		test_name = '{"commands", "axis_values", "errors", "comments", "back_to_back"};
		rng = 32'hee95_bd4e;
		reset = 1'b1;
		char_valid = 1'b0;
		char_in = '0;
		add_line(0, "G0");
		add_line(0, "G1 X10");
		add_line(0, "G28");
		add_line(0, "G90");
		add_line(0, "G91");
		add_line(1, "G1 X-1.5");
		add_line(1, "G0 Z.25");
		add_line(1, "G1 X12 Y-3.125 Z0.5");
		add_line(1, "g1 y7.05");
		for (int i = 0; i < 12; i++) add_line(1, random_line());
		add_line(2, "G5 X1");
		add_line(2, "X1 Y2");
		add_line(2, "G1 X1 #");
		add_line(2, "G1 X1 X2");
		add_line(2, "G1 Y1.2345");
		add_line(2, "G1 X-");
		add_line(3, "G1 X2 ; move Y9");
		add_line(3, "; only a comment");
		add_line(3, "");
		add_line(3, "   ");
		add_line(3, "G0 Y-4;Z1");
		add_line(4, "G0 X1");
		add_line(4, "G1 Y2.5");
		add_line(4, "");
		add_line(4, "X3 Z-0.001");
		add_line(4, "G28");
		add_line(4, "G1 Z7");
		total = 0;
		foreach (lines[n]) total += lines[n].len() + 1;  // newline included
		cycle_limit = 2 * total + 100;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		last_test = 0;
		n_lines = 0;
		errors_before = 0;
		for (int n = 0; n < lines.size(); n++) begin
			if (line_test[n] != last_test) begin
				finish_test(last_test, n_lines, errors_before);
				last_test = line_test[n];
				n_lines = 0;
			end
			send_line(lines[n], line_test[n] != 4);  // last test runs without gaps
			n_lines++;
		end
		finish_test(last_test, n_lines, errors_before);
		$display("summary: 5 tests, %0d lines, %0d operations, %0d errors", lines.size(),
			rd_cnt, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* gcode_line_parser.sv */
`timescale 1ns/10ps

module gcode_line_parser #(
	parameter int NUM_AXES = 3,
	parameter int COORD_BITS = gcode_pkg::COORD_BITS
) (
	input logic clk,
	input logic reset,
	input logic char_valid,
	input gcode_pkg::byte_t char_in,
	output logic op_valid,
	output gcode_pkg::cmd_t op_cmd,
	output logic [NUM_AXES-1:0] op_axis_present,
	output logic [NUM_AXES-1:0][COORD_BITS-1:0] op_axis_value,
	output logic op_error
);

	logic cmd_start;
	logic [NUM_AXES-1:0] axis_start;
	logic num_digit;
	gcode_pkg::digit_t digit;
	logic num_minus;
	logic num_point;
	logic field_end;
	logic line_end;
	logic line_bad;
	logic line_nonempty;
	gcode_pkg::cmd_t cmd;
	logic cmd_seen;
	logic cmd_valid;
	logic [NUM_AXES-1:0] axis_present;
	logic [NUM_AXES-1:0][COORD_BITS-1:0] axis_value;
	logic [NUM_AXES-1:0] axis_error;

	line_tokenizer #(
		.NUM_AXES(NUM_AXES)
	) i_line_tokenizer (
		.clk(clk),
		.reset(reset),
		.char_valid(char_valid),
		.char_in(char_in),
		.cmd_start(cmd_start),
		.axis_start(axis_start),
		.num_digit(num_digit),
		.digit(digit),
		.num_minus(num_minus),
		.num_point(num_point),
		.field_end(field_end),
		.line_end(line_end),
		.line_bad(line_bad),
		.line_nonempty(line_nonempty)
	);

	cmd_word_parser i_cmd_word_parser (
		.clk(clk),
		.reset(reset),
		.cmd_start(cmd_start),
		.num_digit(num_digit),
		.digit(digit),
		.num_minus(num_minus),
		.num_point(num_point),
		.field_end(field_end),
		.line_end(line_end),
		.cmd(cmd),
		.cmd_seen(cmd_seen),
		.cmd_valid(cmd_valid)
	);

	// one lane per axis letter
	for (genvar i = 0; i < NUM_AXES; i++) begin : g_lane
		axis_word_parser #(
			.COORD_BITS(COORD_BITS)
		) i_axis_word_parser (
			.clk(clk),
			.reset(reset),
			.field_start(axis_start[i]),
			.num_digit(num_digit),
			.digit(digit),
			.num_minus(num_minus),
			.num_point(num_point),
			.field_end(field_end),
			.line_end(line_end),
			.axis_present(axis_present[i]),
			.axis_value(axis_value[i]),
			.axis_error(axis_error[i])
		);
	end

	op_assembler #(
		.NUM_AXES(NUM_AXES),
		.COORD_BITS(COORD_BITS)
	) i_op_assembler (
		.clk(clk),
		.reset(reset),
		.line_end(line_end),
		.line_bad(line_bad),
		.line_nonempty(line_nonempty),
		.cmd(cmd),
		.cmd_seen(cmd_seen),
		.cmd_valid(cmd_valid),
		.axis_present(axis_present),
		.axis_value(axis_value),
		.axis_error(axis_error),
		.op_valid(op_valid),
		.op_cmd(op_cmd),
		.op_axis_present(op_axis_present),
		.op_axis_value(op_axis_value),
		.op_error(op_error)
	);

endmodule

/* op_assembler.sv */
`timescale 1ns/10ps

module op_assembler #(
	parameter int NUM_AXES = 3,
	parameter int COORD_BITS = gcode_pkg::COORD_BITS
) (
	input logic clk,
	input logic reset,
	input logic line_end,
	input logic line_bad,
	input logic line_nonempty,
	input gcode_pkg::cmd_t cmd,
	input logic cmd_seen,
	input logic cmd_valid,
	input logic [NUM_AXES-1:0] axis_present,
	input logic [NUM_AXES-1:0][COORD_BITS-1:0] axis_value,
	input logic [NUM_AXES-1:0] axis_error,
	output logic op_valid,
	output gcode_pkg::cmd_t op_cmd,
	output logic [NUM_AXES-1:0] op_axis_present,
	output logic [NUM_AXES-1:0][COORD_BITS-1:0] op_axis_value,
	output logic op_error
);

	logic take;  // finished line with at least one word
	logic no_cmd;
	logic bad_cmd;
	logic lane_err;

	assign take = line_end && line_nonempty;
	assign no_cmd = !cmd_seen;
	assign bad_cmd = cmd_seen && !cmd_valid;
	assign lane_err = |axis_error;

	always_ff @(posedge clk) begin
		if (reset) op_valid <= 1'b0;
		else op_valid <= take;
	end

	always_ff @(posedge clk) begin
		if (take) begin
			op_cmd <= cmd;
			op_axis_present <= axis_present;
			op_axis_value <= axis_value;
			op_error <= line_bad || no_cmd || bad_cmd || lane_err;
		end
	end

	// line_end never repeats on consecutive cycles for a non-empty line
	a_op_single: assert property (@(posedge clk) disable iff (reset)
		op_valid |=> !op_valid)
		else $error("[ERROR] op_valid high for two cycles");

endmodule

/* axis_word_parser.sv */
`timescale 1ns/10ps

module axis_word_parser #(
	parameter int COORD_BITS = gcode_pkg::COORD_BITS
) (
	input logic clk,
	input logic reset,
	input logic field_start,
	input logic num_digit,
	input gcode_pkg::digit_t digit,
	input logic num_minus,
	input logic num_point,
	input logic field_end,
	input logic line_end,
	output logic axis_present,
	output logic signed [COORD_BITS-1:0] axis_value,
	output logic axis_error
);

	localparam int FRAC = gcode_pkg::FRAC_DIGITS;
	localparam int CNT_BITS = $clog2(FRAC + 1);

	logic own;  // number characters belong to this lane
	logic neg;
	logic seen_point;
	logic started;
	logic has_digit;
	logic err;
	logic [CNT_BITS-1:0] frac_cnt;
	logic [COORD_BITS-1:0] mag;  // all digits so far, point ignored
	logic [COORD_BITS-1:0] mag_next;
	logic [COORD_BITS-1:0] scaled;

	// pad the missing fraction digits with zeros
	function automatic logic [COORD_BITS-1:0] pad_frac(input logic [COORD_BITS-1:0] m,
			input logic [CNT_BITS-1:0] cnt);
		logic [COORD_BITS-1:0] v;
		v = m;
		for (int i = 0; i < FRAC; i++) begin
			if (i >= int'(cnt)) v = v * COORD_BITS'(10);
		end
		return v;
	endfunction

	assign mag_next = mag * COORD_BITS'(10) + COORD_BITS'(digit);
	assign scaled = pad_frac(mag, frac_cnt);
	assign axis_value = neg ? -scaled : scaled;
	assign axis_error = err || (axis_present && !has_digit);  // field without digits

	always_ff @(posedge clk) begin
		if (reset || line_end) begin
			axis_present <= 1'b0;
			own <= 1'b0;
			neg <= 1'b0;
			seen_point <= 1'b0;
			started <= 1'b0;
			has_digit <= 1'b0;
			err <= 1'b0;
			frac_cnt <= '0;
			mag <= '0;
		end else begin
			if (field_end) own <= 1'b0;
			if (own && num_digit) begin
				has_digit <= 1'b1;
				started <= 1'b1;
				if (!seen_point) mag <= mag_next;
				else if (frac_cnt == CNT_BITS'(FRAC)) err <= 1'b1;  // too many fraction digits
				else begin
					mag <= mag_next;
					frac_cnt <= frac_cnt + 1'b1;
				end
			end
			if (own && num_minus) begin
				if (started) err <= 1'b1;  // sign only in front
				neg <= 1'b1;
				started <= 1'b1;
			end
			if (own && num_point) begin
				if (seen_point) err <= 1'b1;
				seen_point <= 1'b1;
				started <= 1'b1;
			end
			if (field_start) begin
				if (axis_present) err <= 1'b1;  // same axis twice
				axis_present <= 1'b1;
				own <= 1'b1;
				neg <= 1'b0;
				seen_point <= 1'b0;
				started <= 1'b0;
				has_digit <= 1'b0;
				frac_cnt <= '0;
				mag <= '0;
			end
		end
	end

	a_start_not_at_line_end: assert property (@(posedge clk) disable iff (reset)
		!(field_start && line_end))
		else $error("[ERROR] field_start together with line_end");

endmodule

/* cmd_word_parser.sv */
`timescale 1ns/10ps

module cmd_word_parser (
	input logic clk,
	input logic reset,
	input logic cmd_start,
	input logic num_digit,
	input gcode_pkg::digit_t digit,
	input logic num_minus,
	input logic num_point,
	input logic field_end,
	input logic line_end,
	output gcode_pkg::cmd_t cmd,
	output logic cmd_seen,
	output logic cmd_valid
);

	typedef enum logic {IDLE, NUMBER} state_t;

	state_t state;
	gcode_pkg::gnum_t gnum;
	gcode_pkg::cmd_t code;
	logic [10:0] gnum_wide;  // gnum*10 + digit before saturation
	logic has_digit;
	logic err;

	assign gnum_wide = 11'(gnum) * 11'd10 + 11'(digit);

	always_ff @(posedge clk) begin
		if (reset || line_end) begin
			state <= IDLE;
			gnum <= '0;
			cmd_seen <= 1'b0;
			has_digit <= 1'b0;
			err <= 1'b0;
		end else begin
			if (field_end) state <= IDLE;
			if (state == NUMBER) begin
				if (num_digit) begin
					has_digit <= 1'b1;
					gnum <= (gnum_wide > 11'(gcode_pkg::GNUM_MAX)) ?
						gcode_pkg::GNUM_MAX : gnum_wide[6:0];
				end
				if (num_minus || num_point) err <= 1'b1;  // codes are plain integers
			end
			if (cmd_start) begin
				if (cmd_seen) err <= 1'b1;  // second g on the line
				cmd_seen <= 1'b1;
				state <= NUMBER;
				gnum <= '0;
				has_digit <= 1'b0;
			end
		end
	end

	always_comb begin
		case (gnum)
			gcode_pkg::G_RAPID: code = gcode_pkg::CMD_RAPID;
			gcode_pkg::G_LINEAR: code = gcode_pkg::CMD_LINEAR;
			gcode_pkg::G_HOME: code = gcode_pkg::CMD_HOME;
			gcode_pkg::G_ABSOLUTE: code = gcode_pkg::CMD_ABSOLUTE;
			gcode_pkg::G_RELATIVE: code = gcode_pkg::CMD_RELATIVE;
			default: code = gcode_pkg::CMD_NONE;
		endcase
	end

	assign cmd = has_digit ? code : gcode_pkg::CMD_NONE;
	assign cmd_valid = cmd_seen && has_digit && !err && (code != gcode_pkg::CMD_NONE);

endmodule

/* line_tokenizer.sv */
`timescale 1ns/10ps

module line_tokenizer #(
	parameter int NUM_AXES = 3
) (
	input logic clk,
	input logic reset,
	input logic char_valid,
	input gcode_pkg::byte_t char_in,
	output logic cmd_start,
	output logic [NUM_AXES-1:0] axis_start,
	output logic num_digit,
	output gcode_pkg::digit_t digit,
	output logic num_minus,
	output logic num_point,
	output logic field_end,
	output logic line_end,
	output logic line_bad,
	output logic line_nonempty
);

	localparam int IDX_BITS = (NUM_AXES > 1) ? $clog2(NUM_AXES) : 1;

	typedef enum logic [1:0] {IDLE, IN_FIELD, IN_COMMENT} state_t;

	state_t state;
	state_t state_next;
	gcode_pkg::byte_t char_q;
	logic char_q_valid;
	gcode_pkg::char_class_t char_class;
	logic [IDX_BITS-1:0] axis_index;
	logic in_field;
	logic bad_char;

	if (NUM_AXES < 1 || NUM_AXES > $size(gcode_pkg::AXIS_LETTERS)) begin : g_axes_check
		$error("NUM_AXES out of range for the axis letter table");
	end

	char_classifier #(
		.NUM_AXES(NUM_AXES)
	) i_char_classifier (
		.char_in(char_q),
		.char_class(char_class),
		.digit(digit),
		.axis_index(axis_index)
	);

	assign in_field = (state == IN_FIELD);

	// strobes for the stored character
	always_comb begin
		cmd_start = 1'b0;
		axis_start = '0;
		num_digit = 1'b0;
		num_minus = 1'b0;
		num_point = 1'b0;
		field_end = 1'b0;
		line_end = 1'b0;
		bad_char = 1'b0;
		state_next = state;
		if (char_q_valid && state == IN_COMMENT) begin
			if (char_class == gcode_pkg::CLS_NEWLINE) begin
				line_end = 1'b1;
				state_next = IDLE;
			end
		end else if (char_q_valid) begin
			case (char_class)
				gcode_pkg::CLS_LETTER_G: begin
					cmd_start = 1'b1;
					field_end = in_field;  // letter closes the open field
					state_next = IN_FIELD;
				end
				gcode_pkg::CLS_LETTER_AXIS: begin
					axis_start[axis_index] = 1'b1;
					field_end = in_field;
					state_next = IN_FIELD;
				end
				gcode_pkg::CLS_DIGIT: num_digit = in_field;
				gcode_pkg::CLS_MINUS: num_minus = in_field;
				gcode_pkg::CLS_POINT: num_point = in_field;
				gcode_pkg::CLS_SPACE: begin
					field_end = in_field;
					state_next = IDLE;
				end
				gcode_pkg::CLS_COMMENT: begin
					field_end = in_field;
					state_next = IN_COMMENT;
				end
				gcode_pkg::CLS_NEWLINE: begin
					field_end = in_field;
					line_end = 1'b1;
					state_next = IDLE;
				end
				default: bad_char = 1'b1;
			endcase
			// number character outside any field
			if (!in_field && (char_class == gcode_pkg::CLS_DIGIT ||
					char_class == gcode_pkg::CLS_MINUS ||
					char_class == gcode_pkg::CLS_POINT))
				bad_char = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (char_valid) char_q <= char_in;
		if (reset) begin
			char_q_valid <= 1'b0;
			state <= IDLE;
			line_bad <= 1'b0;
			line_nonempty <= 1'b0;
		end else begin
			char_q_valid <= char_valid;
			state <= state_next;
			if (line_end) begin  // flags already sampled by the assembler
				line_bad <= 1'b0;
				line_nonempty <= 1'b0;
			end else begin
				if (bad_char) line_bad <= 1'b1;
				if (cmd_start || (|axis_start)) line_nonempty <= 1'b1;
			end
		end
	end

	// the source holds off while reset is high
	a_no_char_in_reset: assert property (@(posedge clk) reset |-> !char_valid)
		else $error("[ERROR] char_valid high while reset is high");

endmodule

/* char_classifier.sv */
`timescale 1ns/10ps

module char_classifier #(
	parameter int NUM_AXES = 3,
	localparam int IDX_BITS = (NUM_AXES > 1) ? $clog2(NUM_AXES) : 1
) (
	input gcode_pkg::byte_t char_in,
	output gcode_pkg::char_class_t char_class,
	output gcode_pkg::digit_t digit,
	output logic [IDX_BITS-1:0] axis_index
);

	gcode_pkg::byte_t upper;
	logic axis_hit;

	// fold lower case onto upper case
	assign upper = (char_in >= "a" && char_in <= "z") ? char_in - 8'd32 : char_in;

	assign digit = char_in[3:0];  // meaningful for digits only

	always_comb begin
		axis_hit = 1'b0;
		axis_index = '0;
		for (int i = 0; i < NUM_AXES; i++) begin
			if (upper == gcode_pkg::AXIS_LETTERS[i]) begin
				axis_hit = 1'b1;
				axis_index = IDX_BITS'(i);
			end
		end
	end

	always_comb begin
		if (char_in >= "0" && char_in <= "9") char_class = gcode_pkg::CLS_DIGIT;
		else if (upper == "G") char_class = gcode_pkg::CLS_LETTER_G;
		else if (axis_hit) char_class = gcode_pkg::CLS_LETTER_AXIS;
		else if (char_in == "-") char_class = gcode_pkg::CLS_MINUS;
		else if (char_in == ".") char_class = gcode_pkg::CLS_POINT;
		else if (char_in == " " || char_in == "\t" || char_in == "\r")
			char_class = gcode_pkg::CLS_SPACE;  // cr treated as blank
		else if (char_in == ";") char_class = gcode_pkg::CLS_COMMENT;
		else if (char_in == "\n") char_class = gcode_pkg::CLS_NEWLINE;
		else char_class = gcode_pkg::CLS_OTHER;
	end

endmodule

/* gcode_pkg.sv */
package gcode_pkg;

	typedef logic [7:0] byte_t;  // one ascii character
	typedef logic [3:0] digit_t;

	// signed axis value in thousandths of a unit
	localparam int COORD_BITS = 24;
	typedef logic signed [COORD_BITS-1:0] coord_t;

	// fraction digits kept after the point
	localparam int FRAC_DIGITS = 3;

	typedef logic [6:0] gnum_t;  // g number, saturating
	localparam gnum_t GNUM_MAX = 7'd127;

	// supported g codes
	localparam gnum_t G_RAPID    = 7'd0;
	localparam gnum_t G_LINEAR   = 7'd1;
	localparam gnum_t G_HOME     = 7'd28;
	localparam gnum_t G_ABSOLUTE = 7'd90;
	localparam gnum_t G_RELATIVE = 7'd91;

	typedef enum logic [2:0] {
		CMD_RAPID,
		CMD_LINEAR,
		CMD_HOME,
		CMD_ABSOLUTE,
		CMD_RELATIVE,
		CMD_NONE
	} cmd_t;

	typedef enum logic [3:0] {
		CLS_DIGIT,
		CLS_LETTER_G,
		CLS_LETTER_AXIS,
		CLS_MINUS,
		CLS_POINT,
		CLS_SPACE,
		CLS_COMMENT,
		CLS_NEWLINE,
		CLS_OTHER
	} char_class_t;

	// axis letters by lane, lane 0 in the low byte
	localparam byte_t [2:0] AXIS_LETTERS = {"Z", "Y", "X"};

endpackage
